// ==== design/cacheCtrlRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheCtrlRegs (
    input logic clk,
    input logic rst,
    input logic rdy,
    input logic cfgReq,
    input fetchPkg::ctrlCmd cmd,
    output logic cfgAck,
    output logic cacheEn,
    output logic flushPulse,
    input logic refillStart,
    output logic [15:0] missCount
);

    // first cycle of a request, before our ack
    logic cmdFire;

    assign cmdFire = cfgReq && !cfgAck;

    // four-phase slave and command decode
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfgAck <= 1'b0;
            cacheEn <= 1'b1;
            flushPulse <= 1'b0;
        end else if (rdy) begin
            // strobe lasts one active cycle
            flushPulse <= 1'b0;
            if (cmdFire) begin
                cfgAck <= 1'b1;
                case (cmd.op)
                    fetchPkg::OpEnable: cacheEn <= 1'b1;
                    fetchPkg::OpDisable: cacheEn <= 1'b0;
                    fetchPkg::OpFlush: flushPulse <= 1'b1;
                    default: ;
                endcase
            end else if (!cfgReq && cfgAck) begin
                // master let go, close the handshake
                cfgAck <= 1'b0;
            end
        end
    end

    // miss counter
    // saturates at all ones, clear wins over a same-cycle miss
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            missCount <= '0;
        end else if (rdy) begin
            if (cmdFire && cmd.clearCount) begin
                missCount <= '0;
            end else if (refillStart && (missCount != 16'hffff)) begin
                missCount <= missCount + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/fetchTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetchTop (
    input logic clk,
    input logic rst,
    input logic rdy,
    output logic instReq,
    output fetchPkg::instBeat outBeat,
    input logic instAck,
    input fetchPkg::redirectCmd redirect,
    input logic cfgReq,
    input fetchPkg::ctrlCmd cmd,
    output logic cfgAck,
    output logic [15:0] missCount,
    output logic memRe,
    output logic [`AddrWidth-1:0] memAddr,
    input logic [7:0] memData
);

    // fetch to cache lookup
    logic [`AddrWidth-1:0] fetchPc;
    logic hit;
    logic [`WordWidth-1:0] hitInst;

    // miss path
    fetchPkg::refillReq refill;
    fetchPkg::refillDone fill;

    // cache steering from the control block
    logic cacheEn;
    logic flushPulse;

    fetchUnit uFetch (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .fetchPc(fetchPc),
        .hit(hit),
        .hitInst(hitInst),
        .refill(refill),
        .fill(fill),
        .redirect(redirect),
        .instReq(instReq),
        .outBeat(outBeat),
        .instAck(instAck)
    );

    instCache uCache (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .lookupAddr(fetchPc),
        .hit(hit),
        .hitInst(hitInst),
        .fill(fill),
        .cacheEn(cacheEn),
        .flushPulse(flushPulse)
    );

    memRefill uRefill (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .refill(refill),
        .fill(fill),
        .memRe(memRe),
        .memAddr(memAddr),
        .memData(memData)
    );

    // every refill start counts as a miss
    cacheCtrlRegs uCtrl (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .cfgReq(cfgReq),
        .cmd(cmd),
        .cfgAck(cfgAck),
        .cacheEn(cacheEn),
        .flushPulse(flushPulse),
        .refillStart(refill.start),
        .missCount(missCount)
    );

endmodule

`default_nettype wire

// ==== design/fetchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetchUnit (
    input logic clk,
    input logic rst,
    input logic rdy,
    output logic [`AddrWidth-1:0] fetchPc,
    input logic hit,
    input logic [`WordWidth-1:0] hitInst,
    output fetchPkg::refillReq refill,
    input fetchPkg::refillDone fill,
    input fetchPkg::redirectCmd redirect,
    output logic instReq,
    output fetchPkg::instBeat outBeat,
    input logic instAck
);

    fetchPkg::fetchState state;
    logic [`AddrWidth-1:0] pc;

    // jump waiting for the next pc change point
    logic pendValid;
    logic [`AddrWidth-1:0] pendTarget;

    // held word for decode
    fetchPkg::instBeat beat;

    assign fetchPc = pc;
    assign outBeat = beat;

    // miss found this cycle
    assign refill.start = (state == fetchPkg::Lookup) && !hit;
    assign refill.addr = pc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= fetchPkg::Lookup;
            pc <= `ResetPc;
            instReq <= 1'b0;
            pendValid <= 1'b0;
        end else if (rdy) begin
            case (state)
                fetchPkg::Lookup: begin
                    if (hit) begin
                        instReq <= 1'b1;
                        state <= fetchPkg::Present;
                    end else begin
                        state <= fetchPkg::WaitRefill;
                    end
                end
                fetchPkg::WaitRefill: begin
                    if (fill.done) begin
                        if (pendValid) begin
                            // refilled word is stale, go to the jump target
                            pc <= pendTarget;
                            pendValid <= 1'b0;
                            state <= fetchPkg::Lookup;
                        end else begin
                            instReq <= 1'b1;
                            state <= fetchPkg::Present;
                        end
                    end
                end
                fetchPkg::Present: begin
                    // beat taken, move on
                    if (instAck) begin
                        instReq <= 1'b0;
                        pc <= pendValid ? pendTarget : pc + `AddrWidth'(4);
                        pendValid <= 1'b0;
                        state <= fetchPkg::WaitAckLow;
                    end
                end
                default: begin
                    // wait for decode to drop ack
                    if (!instAck) begin
                        state <= fetchPkg::Lookup;
                    end
                end
            endcase
            // a new jump overrides one consumed this cycle
            if (redirect.valid) begin
                pendValid <= 1'b1;
            end
        end
    end

    // beat and jump target registers
    always_ff @(posedge clk) begin
        if (rdy) begin
            if ((state == fetchPkg::Lookup) && hit) begin
                beat.pc <= pc;
                beat.inst <= hitInst;
            end else if ((state == fetchPkg::WaitRefill) && fill.done) begin
                // word comes straight from the refill engine
                beat.pc <= pc;
                beat.inst <= fill.data;
            end
            if (redirect.valid) begin
                pendTarget <= redirect.target;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_defines.svh ====
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// byte address into main memory
`define AddrWidth 17

// one instruction word
`define WordWidth 32

// direct-mapped line count, one word per line
`define CacheLines 128

// tag field of a byte address
`define TagHi 16
`define TagLo 9
`define TagWidth (`TagHi - `TagLo + 1)

// line index field of a byte address
`define IndexHi 8
`define IndexLo 2
`define IndexWidth (`IndexHi - `IndexLo + 1)

// first fetch address out of reset
`define ResetPc 17'h0_0000

`endif

// ==== design/fetch_pkg.sv ====
`default_nettype none

`include "fetch_defines.svh"

package fetchPkg;

    // fetch sequencer states
    typedef enum logic [1:0] {
        Lookup,
        WaitRefill,
        Present,
        WaitAckLow
    } fetchState;

    // refill engine states, one per byte read
    typedef enum logic [2:0] {
        Idle,
        Read0,
        Read1,
        Read2,
        Read3,
        Finish
    } refillState;

    // control channel opcodes
    typedef enum logic [1:0] {
        OpNop,
        OpEnable,
        OpDisable,
        OpFlush
    } ctrlOp;

    typedef struct packed {
        ctrlOp op;
        logic clearCount;
    } ctrlCmd;

    // beat handed to decode
    typedef struct packed {
        logic [`AddrWidth-1:0] pc;
        logic [`WordWidth-1:0] inst;
    } instBeat;

    // jump from execute
    typedef struct packed {
        logic valid;
        logic [`AddrWidth-1:0] target;
    } redirectCmd;

    typedef struct packed {
        logic start;
        logic [`AddrWidth-1:0] addr;
    } refillReq;

    typedef struct packed {
        logic done;
        logic [`AddrWidth-1:0] addr;
        logic [`WordWidth-1:0] data;
    } refillDone;

endpackage

`default_nettype wire

// ==== design/instCache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module instCache (
    input logic clk,
    input logic rst,
    input logic rdy,
    input logic [`AddrWidth-1:0] lookupAddr,
    output logic hit,
    output logic [`WordWidth-1:0] hitInst,
    input fetchPkg::refillDone fill,
    input logic cacheEn,
    input logic flushPulse
);

    // per-line storage
    logic [`WordWidth-1:0] instMem [`CacheLines];
    logic [`TagWidth-1:0] tagMem [`CacheLines];
    logic [`CacheLines-1:0] validBits;

    // lookup side address split
    logic [`TagWidth-1:0] lookupTag;
    logic [`IndexWidth-1:0] lookupIndex;

    // fill side address split
    logic [`TagWidth-1:0] fillTag;
    logic [`IndexWidth-1:0] fillIndex;
    logic fillWrite;

    assign lookupTag = lookupAddr[`TagHi:`TagLo];
    assign lookupIndex = lookupAddr[`IndexHi:`IndexLo];
    assign fillTag = fill.addr[`TagHi:`TagLo];
    assign fillIndex = fill.addr[`IndexHi:`IndexLo];

    // a disabled cache never reports a hit
    assign hit = cacheEn && validBits[lookupIndex]
                 && (tagMem[lookupIndex] == lookupTag);

    // word goes out even on a miss, fetch ignores it then
    assign hitInst = instMem[lookupIndex];

    // lines are only written while the cache is on
    assign fillWrite = rdy && fill.done && cacheEn;

    // valid bits
    // flush beats a fill in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validBits <= '0;
        end else if (rdy) begin
            if (flushPulse) begin
                validBits <= '0;
            end else if (fillWrite) begin
                validBits[fillIndex] <= 1'b1;
            end
        end
    end

    // instruction and tag arrays
    always_ff @(posedge clk) begin
        if (fillWrite) begin
            instMem[fillIndex] <= fill.data;
            tagMem[fillIndex] <= fillTag;
        end
    end

endmodule

`default_nettype wire

// ==== design/memRefill.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module memRefill (
    input logic clk,
    input logic rst,
    input logic rdy,
    input fetchPkg::refillReq refill,
    output fetchPkg::refillDone fill,
    output logic memRe,
    output logic [`AddrWidth-1:0] memAddr,
    input logic [7:0] memData
);

    fetchPkg::refillState state;

    // word-aligned part of the miss address
    logic [`AddrWidth-3:0] wordAddr;

    // byte slot read in the current state
    logic [1:0] lane;
    logic reading;

    // last cycle's read, its byte is on memData now
    logic readPending;
    logic [1:0] pendingLane;

    // bytes gathered so far and the view with memData folded in
    logic [`WordWidth-1:0] wordBuf;
    logic [`WordWidth-1:0] merged;

    always_comb begin
        reading = 1'b1;
        case (state)
            fetchPkg::Read0: lane = 2'd0;
            fetchPkg::Read1: lane = 2'd1;
            fetchPkg::Read2: lane = 2'd2;
            fetchPkg::Read3: lane = 2'd3;
            default: begin
                lane = 2'd0;
                reading = 1'b0;
            end
        endcase
    end

    // a read is only issued in a cycle that advances
    // so memRe never stretches during a stall
    assign memRe = reading && rdy;
    assign memAddr = {wordAddr, lane};

    // little-endian placement of the returned byte
    always_comb begin
        merged = wordBuf;
        if (readPending) begin
            merged[pendingLane*8 +: 8] = memData;
        end
    end

    // word is complete once the last byte is merged
    assign fill.done = (state == fetchPkg::Finish);
    assign fill.addr = {wordAddr, 2'b00};
    assign fill.data = merged;

    // read sequencer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= fetchPkg::Idle;
        end else if (rdy) begin
            case (state)
                fetchPkg::Idle: begin
                    if (refill.start) begin
                        state <= fetchPkg::Read0;
                    end
                end
                fetchPkg::Read0: state <= fetchPkg::Read1;
                fetchPkg::Read1: state <= fetchPkg::Read2;
                fetchPkg::Read2: state <= fetchPkg::Read3;
                fetchPkg::Read3: state <= fetchPkg::Finish;
                default: state <= fetchPkg::Idle;
            endcase
        end
    end

    // memory answers a cycle later whatever rdy does
    // so the response is tracked every clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            readPending <= 1'b0;
        end else begin
            readPending <= memRe;
        end
    end

    always_ff @(posedge clk) begin
        pendingLane <= lane;
        wordBuf <= merged;
        if (rdy && (state == fetchPkg::Idle) && refill.start) begin
            wordAddr <= refill.addr[`AddrWidth-1:2];
        end
    end

endmodule

`default_nettype wire

// ==== dv/fetchTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetchTb;

    // beats over all tests, sizes the watchdog
    localparam int ExpectedBeats = 32 + 32 + 8 + 24 + 40;
    localparam int CyclesPerBeat = 200;
    localparam int MemBytes = 1 << `AddrWidth;
    localparam logic [31:0] Seed = 32'h0a1b_42b9;

    logic clk;
    logic rst;
    logic rdy;
    logic instReq;
    fetchPkg::instBeat outBeat;
    logic instAck;
    fetchPkg::redirectCmd redirect;
    logic cfgReq;
    fetchPkg::ctrlCmd cmd;
    logic cfgAck;
    logic [15:0] missCount;
    logic memRe;
    logic [`AddrWidth-1:0] memAddr;
    logic [7:0] memData;

    // byte-wide main memory
    logic [7:0] mem [MemBytes];

    // decode side, beats taken so far and how many to take
    fetchPkg::instBeat gotBeats[$];
    int ackLimit;
    logic ackBusy;
    logic ackRandom;
    logic rdyRandom;
    logic redirecting;
    int memReads;
    int errorCount;
    int checkCount;
    int expMiss;

    fetchTop uut (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .instReq(instReq),
        .outBeat(outBeat),
        .instAck(instAck),
        .redirect(redirect),
        .cfgReq(cfgReq),
        .cmd(cmd),
        .cfgAck(cfgAck),
        .missCount(missCount),
        .memRe(memRe),
        .memAddr(memAddr),
        .memData(memData)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // little-endian word from the model
    function automatic logic [31:0] expectedWord(input logic [`AddrWidth-1:0] pc);
        return {mem[pc + `AddrWidth'(3)], mem[pc + `AddrWidth'(2)],
                mem[pc + `AddrWidth'(1)], mem[pc]};
    endfunction

    task automatic checkHex(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errorCount++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // memory answers a read on the next cycle
    initial begin
        logic sampledRe;
        logic [`AddrWidth-1:0] sampledAddr;
        memData = 8'h00;
        memReads = 0;
        forever begin
            @(negedge clk);
            sampledRe = memRe;
            sampledAddr = memAddr;
            if (memRe) begin
                memReads++;
            end
            @(posedge clk);
            #2;
            if (sampledRe) begin
                memData = mem[sampledAddr];
            end
        end
    end

    // decode responder, takes beats up to ackLimit
    initial begin
        logic [31:0] ackSeed;
        int delay;
        instAck = 1'b0;
        ackBusy = 1'b0;
        ackSeed = Seed;
        forever begin
            @(negedge clk);
            if (!rst && instReq && !instAck && (gotBeats.size() < ackLimit)) begin
                ackBusy = 1'b1;
                gotBeats.push_back(outBeat);
                ackSeed = lcgNext(ackSeed);
                delay = ackRandom ? int'(ackSeed[18:16]) : 0;
                repeat (delay) @(negedge clk);
                @(posedge clk);
                #2;
                instAck = 1'b1;
                // ack held until fetch drops the request
                @(negedge clk);
                while (instReq) @(negedge clk);
                @(posedge clk);
                #2;
                instAck = 1'b0;
                ackBusy = 1'b0;
            end
        end
    end

    // rdy, randomly low about one cycle in four
    initial begin
        logic [31:0] rdySeed;
        rdy = 1'b1;
        rdySeed = Seed;
        forever begin
            @(posedge clk);
            #2;
            rdySeed = lcgNext(rdySeed);
            // kept high across a redirect pulse
            rdy = !(rdyRandom && !redirecting && (rdySeed[29:28] == 2'b00));
        end
    end

    initial begin
        repeat (16 + ExpectedBeats * CyclesPerBeat) @(posedge clk);
        $display("watchdog timeout, the fetch front end stopped delivering beats");
        $display("Regression failed");
        $finish;
    end

    // fetch parked with a beat presenting that decode has not taken
    task automatic waitHeld();
        @(negedge clk);
        while (!(instReq && !ackBusy && (gotBeats.size() == ackLimit))) begin
            @(negedge clk);
        end
    endtask

    task automatic sendRedirect(input logic [`AddrWidth-1:0] target);
        redirecting = 1'b1;
        @(posedge clk);
        #2;
        redirect.valid = 1'b1;
        redirect.target = target;
        @(posedge clk);
        #2;
        redirect.valid = 1'b0;
        redirecting = 1'b0;
    endtask

    task automatic sendCmd(input fetchPkg::ctrlOp op, input logic clear);
        int waited;
        @(posedge clk);
        #2;
        cmd.op = op;
        cmd.clearCount = clear;
        cfgReq = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!cfgAck && (waited < 8)) begin
            @(negedge clk);
            waited++;
        end
        checkCount++;
        assert (cfgAck) else begin
            errorCount++;
            $display("cfgAck did not rise within 8 cycles of cfgReq at %0t", $time);
        end
        @(posedge clk);
        #2;
        cfgReq = 1'b0;
        waited = 0;
        @(negedge clk);
        while (cfgAck && (waited < 8)) begin
            @(negedge clk);
            waited++;
        end
        checkCount++;
        assert (!cfgAck) else begin
            errorCount++;
            $display("cfgAck stayed high after cfgReq fell at %0t", $time);
        end
    endtask

    // fetch lines from start on, last one is left presenting
    // after a jump the beat that was presenting goes first
    task automatic fetchRun(input logic [`AddrWidth-1:0] start, input int lines,
                            input logic jump);
        int base;
        int skip;
        logic [`AddrWidth-1:0] expPc;
        base = gotBeats.size();
        skip = 0;
        if (jump) begin
            sendRedirect(start);
            skip = 1;
        end
        ackLimit = base + skip + lines - 1;
        waitHeld();
        for (int i = 0; i < lines - 1; i++) begin
            expPc = start + `AddrWidth'(4 * i);
            checkHex("outBeat.pc", 32'(gotBeats[base + skip + i].pc), 32'(expPc));
            checkHex("outBeat.inst", gotBeats[base + skip + i].inst, expectedWord(expPc));
        end
        expPc = start + `AddrWidth'(4 * (lines - 1));
        checkHex("outBeat.pc", 32'(outBeat.pc), 32'(expPc));
        checkHex("outBeat.inst", outBeat.inst, expectedWord(expPc));
    endtask

    task automatic testSequential();
        fetchRun(`ResetPc, 32, 1'b0);
        expMiss = 32;
        checkHex("missCount", 32'(missCount), 32'(expMiss));
    endtask

    task automatic testReuse();
        int readsBefore;
        readsBefore = memReads;
        fetchRun(`ResetPc, 32, 1'b1);
        checkHex("memRe cycles", 32'(memReads), 32'(readsBefore));
        checkHex("missCount", 32'(missCount), 32'(expMiss));
    endtask

    // 0 and 512 share line 0
    task automatic testConflict();
        logic [`AddrWidth-1:0] target;
        for (int k = 0; k < 8; k++) begin
            target = (k % 2 == 0) ? `AddrWidth'(512) : `AddrWidth'(0);
            fetchRun(target, 1, 1'b1);
            expMiss++;
            checkHex("missCount", 32'(missCount), 32'(expMiss));
        end
    endtask

    task automatic testControl();
        int readsBefore;
        sendCmd(fetchPkg::OpDisable, 1'b0);
        repeat (2) begin
            fetchRun(`ResetPc, 4, 1'b1);
            expMiss += 4;
            checkHex("missCount", 32'(missCount), 32'(expMiss));
        end
        sendCmd(fetchPkg::OpEnable, 1'b0);
        sendCmd(fetchPkg::OpFlush, 1'b0);
        // flushed, one miss per line
        fetchRun(`ResetPc, 8, 1'b1);
        expMiss += 8;
        checkHex("missCount", 32'(missCount), 32'(expMiss));
        readsBefore = memReads;
        fetchRun(`ResetPc, 8, 1'b1);
        checkHex("missCount", 32'(missCount), 32'(expMiss));
        checkHex("memRe cycles", 32'(memReads), 32'(readsBefore));
        sendCmd(fetchPkg::OpNop, 1'b1);
        expMiss = 0;
        checkHex("missCount", 32'(missCount), 32'(expMiss));
    endtask

    // lines 8 up were flushed or never fetched
    task automatic testBackPressure();
        ackRandom = 1'b1;
        rdyRandom = 1'b1;
        fetchRun(`ResetPc, 40, 1'b1);
        ackRandom = 1'b0;
        rdyRandom = 1'b0;
        expMiss += 32;
        checkHex("missCount", 32'(missCount), 32'(expMiss));
    endtask

    initial begin
        logic [31:0] fillState;
        rst = 1'b1;
        redirect = '0;
        cfgReq = 1'b0;
        cmd = '0;
        ackLimit = 0;
        ackRandom = 1'b0;
        rdyRandom = 1'b0;
        redirecting = 1'b0;
        errorCount = 0;
        checkCount = 0;
        expMiss = 0;
        fillState = Seed;
        for (int a = 0; a < MemBytes; a++) begin
            fillState = lcgNext(fillState);
            mem[a] = fillState[31:24] ^ 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 16);
        end
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        testSequential();
        testReuse();
        testConflict();
        testControl();
        testBackPressure();
        $display("checks %0d, errors %0d, property failures %0d",
                 checkCount, errorCount, uut.props.failCount);
        if ((errorCount == 0) && (uut.props.failCount == 0)) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/fetch_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchProperties (
    input logic clk,
    input logic rst,
    input logic instReq,
    input logic instAck,
    input fetchPkg::instBeat outBeat,
    input logic cfgReq,
    input logic cfgAck,
    input logic memRe
);

    // one failure counter per assertion
    int stableFails = 0;
    int reqRiseFails = 0;
    int ackRiseFails = 0;
    int readRunFails = 0;
    logic [31:0] failCount;

    // consecutive cycles with memRe high before this one
    logic [2:0] readRun;

    assign failCount = stableFails + reqRiseFails + ackRiseFails + readRunFails;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            readRun <= '0;
        end else if (!memRe) begin
            readRun <= '0;
        end else if (readRun != 3'd7) begin
            readRun <= readRun + 3'd1;
        end
    end

    // beat held until decode takes it
    beatStable: assert property (@(posedge clk) disable iff (rst)
        (instReq && !instAck) |=> $stable(outBeat))
        else begin
            stableFails++;
            $error("outBeat changed while instReq waited for instAck");
        end

    // new request only after ack has dropped
    reqRise: assert property (@(posedge clk) disable iff (rst)
        $rose(instReq) |-> !instAck)
        else begin
            reqRiseFails++;
            $error("instReq rose while instAck was still high");
        end

    // control slave answers requests only
    ackRise: assert property (@(posedge clk) disable iff (rst)
        $rose(cfgAck) |-> $past(cfgReq))
        else begin
            ackRiseFails++;
            $error("cfgAck rose without cfgReq");
        end

    // one refill is four byte reads at most
    readRunLimit: assert property (@(posedge clk) disable iff (rst)
        memRe |-> (readRun < 3'd4))
        else begin
            readRunFails++;
            $error("memRe high for more than four cycles in a row");
        end

endmodule

bind fetchTop fetchProperties props (
    .clk(clk),
    .rst(rst),
    .instReq(instReq),
    .instAck(instAck),
    .outBeat(outBeat),
    .cfgReq(cfgReq),
    .cfgAck(cfgAck),
    .memRe(memRe)
);

`default_nettype wire

// ==== project.f ====
+incdir+design
design/fetch_pkg.sv
design/instCache.sv
design/cacheCtrlRegs.sv
design/memRefill.sv
design/fetchUnit.sv
design/fetchTop.sv
dv/fetch_properties.sv
dv/fetchTb.sv

// ==== run.sh ====
#!/bin/sh
# build the fetch front end with Verilator, run it and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module fetchTb -o simFetch \
    || { echo "build failed"; exit 1; }
./obj_dir/simFetch +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qx "Regression passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
